// File: verilog/axis_cdc_cfg.svh
/* stream clock converter configuration
   widths, lane count and FIFO sizing */

`ifndef AXIS_CDC_CFG_SVH
`define AXIS_CDC_CFG_SVH

// beat width in bits
`define AXIS_DATA_WIDTH 32

// number of FIFO lanes, tdest selects one
`define AXIS_LANES 4

// entries per lane, must be a power of two
`define AXIS_FIFO_DEPTH 16

// flops per pointer and reset synchronizer, at least 2
`define AXIS_SYNC_STAGES 2

`endif

// File: verilog/axis_cdc_pkg.sv
/* stream types shared by the converter blocks */

`include "axis_cdc_cfg.svh"

package axis_cdc_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int DATA_W = `AXIS_DATA_WIDTH;
  localparam int LANES  = `AXIS_LANES;

  // one lane still needs a 1-bit tdest
  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

  ////////////////////
  // types
  ////////////////////

  // one beat of payload
  typedef logic [DATA_W-1:0] data_t;

  // lane number carried on tdest
  typedef logic [LANE_W-1:0] lane_t;

  // one bit per lane, request and pop vectors
  typedef logic [LANES-1:0] lane_mask_t;

endpackage

// File: verilog/cdc_fifo_pkg.sv
/* FIFO pointer types, Gray helpers and arbiter slot state */

`include "axis_cdc_cfg.svh"

package cdc_fifo_pkg;

  localparam int ADDR_W = $clog2(`AXIS_FIFO_DEPTH);
  // extra msb is the wrap bit
  localparam int PTR_W  = ADDR_W + 1;

  typedef logic [PTR_W-1:0]  ptr_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // output slot of the arbiter
  typedef enum logic {
    SLOT_EMPTY,
    SLOT_FULL
  } slot_state_e;

  function automatic ptr_t to_gray(ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic ptr_t gray_to_bin(ptr_t g);
    ptr_t b;
    b[PTR_W-1] = g[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

endpackage

// File: verilog/axis_if.sv
/* valid/ready stream bus with lane tag */

interface axis_if;
  import axis_cdc_pkg::*;

  // handshake
  logic  tvalid;
  logic  tready;

  // payload and lane tag
  data_t tdata;
  lane_t tdest;

  // beat producer
  modport source (
    output tvalid,
    output tdata,
    output tdest,
    input  tready
  );

  // beat consumer
  modport sink (
    input  tvalid,
    input  tdata,
    input  tdest,
    output tready
  );

endinterface

// File: verilog/axis_lane_dispatch.sv
/* lane dispatcher: steers input beats to the write bus named by tdest */

`include "axis_cdc_cfg.svh"

module axis_lane_dispatch (
  axis_if.sink   s,
  axis_if.source w [`AXIS_LANES]
);
  import axis_cdc_pkg::*;

  localparam int LANES = `AXIS_LANES;

  // one-hot lane select from tdest
  lane_mask_t lane_sel;
  // tready gathered back from every lane
  lane_mask_t lane_rdy;

  assign lane_sel = lane_mask_t'(1) << s.tdest;

  ////////////////////
  // fan out
  ////////////////////

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    // only the selected lane sees valid
    assign w[i].tvalid = s.tvalid && lane_sel[i];
    // payload goes to all lanes
    assign w[i].tdata  = s.tdata;
    // static lane tag
    assign w[i].tdest  = lane_t'(i);
    assign lane_rdy[i] = w[i].tready;
  end

  // a full lane stalls only beats aimed at it
  assign s.tready = lane_rdy[s.tdest];

  ////////////////////
  // checks
  ////////////////////

  // lane number must be known and in range while a beat is offered
  always_comb begin
    a_dest_range: assert final (!s.tvalid ||
                                (!$isunknown(s.tdest) && int'(s.tdest) < LANES));
  end

endmodule

// File: verilog/axis_fifo_async.sv
/* one dual-clock FWFT FIFO lane
   Gray pointers cross domains through flop synchronizers */

`include "axis_cdc_cfg.svh"

module axis_fifo_async (
  input logic    s_axis_clk,
  input logic    m_axis_clk,
  input logic    rst,
  axis_if.sink   w,
  axis_if.source r
);
  import axis_cdc_pkg::*;
  import cdc_fifo_pkg::*;

  localparam int DEPTH = `AXIS_FIFO_DEPTH;
  localparam int SYNC  = `AXIS_SYNC_STAGES;

  // storage
  data_t mem [DEPTH];

  // write domain
  ptr_t  wr_bin;
  ptr_t  wr_bin_next;
  ptr_t  wr_gray;
  ptr_t  wr_gray_next;
  addr_t wr_addr;
  ptr_t  rd_gray_wq [SYNC];
  logic  wr_full_next;
  logic  wr_ready;
  logic  wr_en;

  // read domain
  logic [SYNC-1:0] rd_rst_q;
  logic  rd_rst;
  ptr_t  rd_bin;
  ptr_t  rd_bin_next;
  ptr_t  rd_gray;
  addr_t rd_addr;
  ptr_t  wr_gray_rq [SYNC];
  logic  rd_empty;
  logic  rd_en;

  ////////////////////
  // write side
  ////////////////////

  assign wr_en        = w.tvalid && wr_ready;
  assign wr_addr      = wr_bin[ADDR_W-1:0];
  assign wr_bin_next  = wr_bin + ptr_t'(wr_en);
  assign wr_gray_next = to_gray(wr_bin_next);

  // full when next write pointer is one lap ahead of the synced read pointer
  // gray form: top two bits inverted, rest equal
  assign wr_full_next = (wr_gray_next == {~rd_gray_wq[SYNC-1][PTR_W-1 -: 2],
                                           rd_gray_wq[SYNC-1][PTR_W-3:0]});

  always_ff @(posedge s_axis_clk) begin
    if (rst) begin
      wr_bin   <= '0;
      wr_gray  <= '0;
      // not ready while in reset
      wr_ready <= 1'b0;
    end else begin
      wr_bin   <= wr_bin_next;
      wr_gray  <= wr_gray_next;
      wr_ready <= !wr_full_next;
    end
  end

  // read pointer into write domain
  always_ff @(posedge s_axis_clk) begin
    if (rst) begin
      for (int i = 0; i < SYNC; i++) begin
        rd_gray_wq[i] <= '0;
      end
    end else begin
      rd_gray_wq[0] <= rd_gray;
      for (int i = 1; i < SYNC; i++) begin
        rd_gray_wq[i] <= rd_gray_wq[i-1];
      end
    end
  end

  always_ff @(posedge s_axis_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= w.tdata;
    end
  end

  assign w.tready = wr_ready;

  ////////////////////
  // read side
  ////////////////////

  // local copy of rst for the m_axis_clk domain
  always_ff @(posedge m_axis_clk) begin
    rd_rst_q <= {rd_rst_q[SYNC-2:0], rst};
  end
  assign rd_rst = rd_rst_q[SYNC-1];

  // write pointer into read domain
  always_ff @(posedge m_axis_clk) begin
    if (rd_rst) begin
      for (int i = 0; i < SYNC; i++) begin
        wr_gray_rq[i] <= '0;
      end
    end else begin
      wr_gray_rq[0] <= wr_gray;
      for (int i = 1; i < SYNC; i++) begin
        wr_gray_rq[i] <= wr_gray_rq[i-1];
      end
    end
  end

  assign rd_empty    = (rd_gray == wr_gray_rq[SYNC-1]);
  assign rd_en       = r.tvalid && r.tready;
  assign rd_addr     = rd_bin[ADDR_W-1:0];
  assign rd_bin_next = rd_bin + ptr_t'(rd_en);

  always_ff @(posedge m_axis_clk) begin
    if (rd_rst) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= to_gray(rd_bin_next);
    end
  end

  // fwft, head word straight from memory
  assign r.tvalid = !rd_empty;
  assign r.tdata  = mem[rd_addr];
  // lane tag is static, safe to pass across
  assign r.tdest  = w.tdest;

  ////////////////////
  // checks
  ////////////////////

  // writes never run more than one lap ahead of what was read
  a_no_write_full: assert property (@(posedge s_axis_clk) disable iff (rst)
    ptr_t'(wr_bin - gray_to_bin(rd_gray_wq[SYNC-1])) <= ptr_t'(DEPTH));

  // the arbiter only pops a lane that shows a head word
  a_no_read_empty: assert property (@(posedge m_axis_clk) disable iff (rd_rst)
    r.tready |-> r.tvalid);

endmodule

// File: verilog/axis_lane_arbiter.sv
/* round-robin drain of the FIFO lanes into one registered output slot */

`include "axis_cdc_cfg.svh"

module axis_lane_arbiter (
  input  logic                m_axis_clk,
  input  logic                rst,
  axis_if.sink                r [`AXIS_LANES],
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output axis_cdc_pkg::data_t m_axis_tdata,
  output axis_cdc_pkg::lane_t m_axis_tdest
);
  import axis_cdc_pkg::*;
  import cdc_fifo_pkg::*;

  localparam int LANES = `AXIS_LANES;
  localparam int SYNC  = `AXIS_SYNC_STAGES;

  logic [SYNC-1:0] rst_q;
  logic        arb_rst;
  lane_mask_t  req;
  lane_mask_t  pop;
  data_t       lane_data [LANES];
  lane_t       last_grant;
  lane_t       grant;
  logic        grant_vld;
  // slot empty or draining this cycle
  logic        slot_load;
  slot_state_e slot_state;
  data_t       slot_data;
  lane_t       slot_dest;

  // rst into m_axis_clk domain
  always_ff @(posedge m_axis_clk) begin
    rst_q <= {rst_q[SYNC-2:0], rst};
  end
  assign arb_rst = rst_q[SYNC-1];

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign req[i]       = r[i].tvalid;
    assign lane_data[i] = r[i].tdata;
    assign r[i].tready  = pop[i];
  end

  ////////////////////
  // grant
  ////////////////////

  // scan from farthest to nearest, the lane just after last_grant wins
  always_comb begin
    int cand;
    grant     = last_grant;
    grant_vld = 1'b0;
    for (int k = LANES; k >= 1; k--) begin
      cand = (int'(last_grant) + k) % LANES;
      if (req[cand]) begin
        grant     = lane_t'(cand);
        grant_vld = 1'b1;
      end
    end
  end

  assign slot_load = (slot_state == SLOT_EMPTY) || m_axis_tready;
  assign pop       = (grant_vld && slot_load) ? (lane_mask_t'(1) << grant) : '0;

  ////////////////////
  // output slot
  ////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (arb_rst) begin
      slot_state <= SLOT_EMPTY;
      // lane 0 is first candidate
      last_grant <= lane_t'(LANES - 1);
    end else if (slot_load) begin
      if (grant_vld) begin
        slot_state <= SLOT_FULL;
        last_grant <= grant;
      end else begin
        slot_state <= SLOT_EMPTY;
      end
    end
  end

  // payload, tdest rebuilt from winning index
  always_ff @(posedge m_axis_clk) begin
    if (slot_load && grant_vld) begin
      slot_data <= lane_data[grant];
      slot_dest <= grant;
    end
  end

  assign m_axis_tvalid = (slot_state == SLOT_FULL);
  assign m_axis_tdata  = slot_data;
  assign m_axis_tdest  = slot_dest;

  // single pop per cycle, and only to a lane with data
  a_one_pop: assert property (@(posedge m_axis_clk) disable iff (arb_rst)
    $onehot0(pop) && ((pop & ~req) == '0));

  // stalled beat holds until taken
  a_slot_hold: assert property (@(posedge m_axis_clk) disable iff (arb_rst)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tdest));

endmodule

// File: verilog/axis_cdc_top.sv
/* multi-lane stream clock converter
   s_axis_clk beats split by tdest into FIFO lanes, merged in m_axis_clk */

`include "axis_cdc_cfg.svh"

module axis_cdc_top (
  // clocks and reset
  input  logic                s_axis_clk,
  input  logic                m_axis_clk,
  input  logic                rst,

  // input stream, s_axis_clk
  input  logic                s_axis_tvalid,
  output logic                s_axis_tready,
  input  axis_cdc_pkg::data_t s_axis_tdata,
  input  axis_cdc_pkg::lane_t s_axis_tdest,

  // output stream, m_axis_clk
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output axis_cdc_pkg::data_t m_axis_tdata,
  output axis_cdc_pkg::lane_t m_axis_tdest
);

  ////////////////////
  // buses
  ////////////////////

  // input side
  axis_if s_bus ();
  // per-lane fifo write side
  axis_if w_bus [`AXIS_LANES] ();
  // per-lane fifo read side
  axis_if r_bus [`AXIS_LANES] ();

  assign s_bus.tvalid  = s_axis_tvalid;
  assign s_bus.tdata   = s_axis_tdata;
  assign s_bus.tdest   = s_axis_tdest;
  assign s_axis_tready = s_bus.tready;

  ////////////////////
  // blocks
  ////////////////////

  // split by tdest
  axis_lane_dispatch i_dispatch (
    .s (s_bus),
    .w (w_bus)
  );

  // one clock-crossing fifo per lane
  for (genvar l = 0; l < `AXIS_LANES; l++) begin : g_fifo
    axis_fifo_async i_fifo (
      .s_axis_clk (s_axis_clk),
      .m_axis_clk (m_axis_clk),
      .rst        (rst),
      .w          (w_bus[l]),
      .r          (r_bus[l])
    );
  end

  // merge lanes onto the output
  axis_lane_arbiter i_arbiter (
    .m_axis_clk    (m_axis_clk),
    .rst           (rst),
    .r             (r_bus),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tdest  (m_axis_tdest)
  );

endmodule

// File: verif/tb_axis_cdc.sv
/* testbench for the multi-lane stream clock converter
   random beats over random lanes, checked against per-lane queues */

`include "axis_cdc_cfg.svh"

module tb_axis_cdc;
  timeunit 1ns;
  timeprecision 100ps;
  import axis_cdc_pkg::*;

  localparam int          DEPTH        = `AXIS_FIFO_DEPTH;
  localparam int          NUM_LANES    = `AXIS_LANES;
  localparam int          RAND_BEATS   = 400;
  // both random runs, lane fill plus the lane 1 beat, full load of every lane
  localparam int          TOTAL_BEATS  = 2 * RAND_BEATS + DEPTH + 2 + NUM_LANES * DEPTH;
  localparam longint      WATCHDOG_NS  = (longint'(TOTAL_BEATS) * 20 + 2000) * 7;
  // output cycles allowed for the model queues to empty after a phase
  localparam int          DRAIN_CYCLES = NUM_LANES * DEPTH * 20;
  localparam logic [31:0] SEED         = 32'h8c74;

  logic  s_axis_clk;
  logic  m_axis_clk;
  logic  rst;
  logic  s_axis_tvalid;
  logic  s_axis_tready;
  data_t s_axis_tdata;
  lane_t s_axis_tdest;
  logic  m_axis_tvalid;
  logic  m_axis_tready;
  data_t m_axis_tdata;
  lane_t m_axis_tdest;

  // separate generator states for the two clock domains
  logic [31:0] stim_state;
  logic [31:0] rdy_state;
  bit          ready_random;
  // expected beats, one queue per lane
  data_t       model_q [NUM_LANES][$];
  // rotation check, active while rr_left is nonzero
  lane_t       rr_lane;
  int          rr_left;

  axis_cdc_top i_dut (
    .s_axis_clk    (s_axis_clk),
    .m_axis_clk    (m_axis_clk),
    .rst           (rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tdest  (s_axis_tdest),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tdest  (m_axis_tdest)
  );

  ////////////////////
  // clocks, watchdog
  ////////////////////

  initial begin
    s_axis_clk = 1'b0;
    forever #2 s_axis_clk = ~s_axis_clk;
  end

  // 7 ns, unrelated to the input clock
  initial begin
    m_axis_clk = 1'b0;
    forever #3.5 m_axis_clk = ~m_axis_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired, output stalled");
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_data(string name, data_t exp, data_t act);
    if (act !== exp) begin
      $display("mismatch at %0.1f ns: %s expected %h actual %h", $realtime, name, exp, act);
      abort_run("data check failed");
    end
  endtask

  task automatic check_lane(string name, lane_t exp, lane_t act);
    if (act !== exp) begin
      $display("mismatch at %0.1f ns: %s expected %0d actual %0d", $realtime, name, exp, act);
      abort_run("lane check failed");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("mismatch at %0.1f ns: %s expected %b actual %b", $realtime, name, exp, act);
      abort_run("flag check failed");
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      $display("mismatch at %0.1f ns: %s expected %0d actual %0d", $realtime, name, exp, act);
      abort_run("count check failed");
    end
  endtask

  function automatic int pending_beats();
    int n;
    n = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      n += model_q[l].size();
    end
    return n;
  endfunction

  // offer one beat from a falling edge, give up after max_wait cycles
  task automatic send_beat(data_t d, lane_t l, int max_wait, output bit accepted);
    int waited;
    waited        = 0;
    accepted      = 1'b0;
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = d;
    s_axis_tdest  = l;
    while (!accepted && waited < max_wait) begin
      @(posedge s_axis_clk);
      accepted = s_axis_tready;
      waited++;
      @(negedge s_axis_clk);
    end
    s_axis_tvalid = 1'b0;
  endtask

  // random beats on random lanes with random idle gaps
  task automatic random_run(int beats);
    bit    ok;
    data_t d;
    lane_t l;
    int    gap;
    for (int n = 0; n < beats; n++) begin
      stim_state = lcg_next(stim_state);
      d          = data_t'(stim_state);
      stim_state = lcg_next(stim_state);
      l          = lane_t'(stim_state[31:24] % NUM_LANES);
      gap        = (stim_state[23:22] == 2'b00) ? int'(stim_state[21:20]) : 0;
      repeat (gap) @(negedge s_axis_clk);
      send_beat(d, l, 2000, ok);
      if (!ok) begin
        abort_run("input beat was never accepted");
      end
    end
  endtask

  // every accepted beat must come out within max_cycles
  task automatic wait_drained(int max_cycles);
    int waited;
    waited = 0;
    while ((rr_left != 0 || pending_beats() != 0) && waited < max_cycles) begin
      @(posedge m_axis_clk);
      waited++;
    end
    // stray output beats would hit an empty queue here
    repeat (20) @(negedge m_axis_clk);
    check_count("beats left in the model", 0, pending_beats());
  endtask

  ////////////////////
  // monitors
  ////////////////////

  // input handshake pushes the model
  always @(posedge s_axis_clk) begin
    if (!rst && s_axis_tvalid && s_axis_tready) begin
      model_q[s_axis_tdest].push_back(s_axis_tdata);
    end
  end

  // output handshake pops the lane named by tdest
  always @(posedge m_axis_clk) begin
    data_t exp;
    if (m_axis_tvalid === 1'b1 && m_axis_tready) begin
      if (model_q[m_axis_tdest].size() == 0) begin
        abort_run("output beat on a lane with no pending input beat");
      end
      exp = model_q[m_axis_tdest].pop_front();
      check_data("m_axis_tdata", exp, m_axis_tdata);
      if (rr_left > 0) begin
        check_lane("m_axis_tdest", rr_lane, m_axis_tdest);
        rr_lane = rr_lane + 1'b1;
        rr_left--;
      end
    end
  end

  // random back-pressure, own domain, own generator
  always @(negedge m_axis_clk) begin
    if (ready_random) begin
      rdy_state = lcg_next(rdy_state);
      m_axis_tready <= rdy_state[16];
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    bit    ok;
    int    filled;
    data_t d;
    rst           = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tdest  = '0;
    m_axis_tready = 1'b0;
    ready_random  = 1'b0;
    stim_state    = SEED;
    rdy_state     = SEED;
    rr_lane       = '0;
    rr_left       = 0;

    // reset state, input side held off
    repeat (4) begin
      @(negedge s_axis_clk);
      check_bit("s_axis_tready", 1'b0, s_axis_tready);
    end
    rst = 1'b0;
    @(negedge m_axis_clk);
    check_bit("m_axis_tvalid", 1'b0, m_axis_tvalid);

    // lane fill with the output stalled since reset
    // capacity is the fifo depth plus the beat parked in the output slot
    @(negedge s_axis_clk);
    filled = 0;
    ok     = 1'b1;
    while (ok && filled <= DEPTH + 2) begin
      stim_state = lcg_next(stim_state);
      send_beat(data_t'(stim_state), lane_t'(2), 40, ok);
      if (ok) begin
        filled++;
      end
    end
    check_count("lane 2 beats accepted", DEPTH + 1, filled);
    // other lanes keep flowing
    stim_state = lcg_next(stim_state);
    send_beat(data_t'(stim_state), lane_t'(1), 1, ok);
    check_bit("s_axis_tready lane 1", 1'b1, ok);
    @(negedge m_axis_clk);
    check_bit("m_axis_tvalid", 1'b1, m_axis_tvalid);
    check_lane("m_axis_tdest", lane_t'(2), m_axis_tdest);

    // top up every lane to a full fifo, lane 1 already holds one
    @(negedge s_axis_clk);
    for (int l = 0; l < NUM_LANES; l++) begin
      if (l != 2) begin
        for (int n = (l == 1) ? 1 : 0; n < DEPTH; n++) begin
          stim_state = lcg_next(stim_state);
          d          = data_t'(stim_state);
          send_beat(d, lane_t'(l), 1, ok);
          check_bit("s_axis_tready", 1'b1, ok);
        end
      end
    end
    // let every lane's write pointer reach the read side
    repeat (20) @(negedge m_axis_clk);

    // strict rotation, starting from the parked lane 2 beat
    rr_lane       = lane_t'(2);
    rr_left       = NUM_LANES * DEPTH;
    m_axis_tready = 1'b1;
    wait_drained(DRAIN_CYCLES);

    // per-lane order, output always ready
    @(negedge s_axis_clk);
    random_run(RAND_BEATS);
    wait_drained(DRAIN_CYCLES);

    // per-lane order under random back-pressure
    @(negedge s_axis_clk);
    ready_random = 1'b1;
    random_run(RAND_BEATS);
    wait_drained(DRAIN_CYCLES);
    ready_random = 1'b0;

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+verilog
verilog/axis_cdc_pkg.sv
verilog/cdc_fifo_pkg.sv
verilog/axis_if.sv
verilog/axis_lane_dispatch.sv
verilog/axis_fifo_async.sv
verilog/axis_lane_arbiter.sv
verilog/axis_cdc_top.sv
verif/tb_axis_cdc.sv
